// ==== demux_settings.svh ====
`ifndef DEMUX_SETTINGS_SVH
`define DEMUX_SETTINGS_SVH

// --------------------
// port and select sizing
// --------------------
`define DMX_NUM_PORTS 4
`define DMX_SEL_W 2

// --------------------
// channel field widths
// --------------------
`define DMX_ID_W 4
`define DMX_ADDR_W 16
`define DMX_DATA_W 16
// beats per burst = len + 1
`define DMX_LEN_W 4

// --------------------
// ordering table sizing
// --------------------
// low id bits that index the in-flight table
`define DMX_LOOK_BITS 2
// all ones on a counter means full
`define DMX_CNT_W 3

`endif

// ==== demux_pkg.sv ====
`default_nettype none

`include "demux_settings.svh"

package demux_pkg;

  // --------------------
  // field types
  // --------------------
  // master port select
  typedef logic [`DMX_SEL_W-1:0] sel_t;
  typedef logic [`DMX_ID_W-1:0] id_t;
  typedef logic [`DMX_ADDR_W-1:0] addr_t;
  typedef logic [`DMX_DATA_W-1:0] data_t;
  typedef logic [`DMX_LEN_W-1:0] len_t;

  // --------------------
  // channel payloads
  // --------------------
  // read address request
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  // request together with its target port
  // payload of the input spill register and the router
  typedef struct packed {
    ar_chan_t ar;
    sel_t     sel;
  } ar_sel_t;

  // read data beat
  typedef struct packed {
    id_t   id;
    data_t data;
    logic  last;
  } r_chan_t;

  // --------------------
  // router FSM
  // --------------------
  // locked: valid is up at a master port, waiting for its ready
  typedef enum logic {
    ROUTE_IDLE   = 1'b0,
    ROUTE_LOCKED = 1'b1
  } route_state_e;

endpackage

`default_nettype wire

// ==== ar_input_reg.sv ====
`default_nettype none

module ar_input_reg (
  input  wire                clk_i,
  input  wire                rst_i,
  // upstream side, slave AR
  input  demux_pkg::ar_sel_t in_i,
  input  wire                in_valid_i,
  output logic               in_ready_o,
  // downstream side, towards the router
  output demux_pkg::ar_sel_t out_o,
  output logic               out_valid_o,
  input  wire                out_ready_i
);

  // slot a takes new requests, slot b holds the spilled older one
  demux_pkg::ar_sel_t a_data_q, b_data_q;
  logic               a_full_q, b_full_q;
  logic               a_fill, a_drain;
  logic               b_fill, b_drain;

  // --------------------
  // handshake control
  // --------------------
  // ready comes from flops only, no path back from out_ready_i
  assign in_ready_o  = !a_full_q || !b_full_q;
  assign out_valid_o = a_full_q || b_full_q;
  // older entry goes first
  assign out_o       = b_full_q ? b_data_q : a_data_q;

  assign a_fill  = in_valid_i && in_ready_o;
  // a leaves when b is free, either downstream or into b
  assign a_drain = a_full_q && !b_full_q;
  // no taker downstream, park it in b
  assign b_fill  = a_drain && !out_ready_i;
  assign b_drain = b_full_q && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill) begin
        a_full_q <= 1'b1;
      end else if (a_drain) begin
        a_full_q <= 1'b0;
      end
      if (b_fill) begin
        b_full_q <= 1'b1;
      end else if (b_drain) begin
        b_full_q <= 1'b0;
      end
    end
  end

  // --------------------
  // payload slots
  // --------------------
  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= in_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

endmodule

`default_nettype wire

// ==== id_inflight_table.sv ====
`default_nettype none

`include "demux_settings.svh"

module id_inflight_table (
  input  wire                          clk_i,
  input  wire                          rst_i,
  // lookup of the request waiting at the router
  input  wire [`DMX_LOOK_BITS-1:0]     lookup_id_i,
  output demux_pkg::sel_t              lookup_sel_o,
  output logic                         occupied_o,
  output logic                         full_o,
  // push on master AR acceptance
  input  wire                          push_i,
  input  wire [`DMX_LOOK_BITS-1:0]     push_id_i,
  input  demux_pkg::sel_t              push_sel_i,
  // slave R port, watched for last beats
  input  demux_pkg::r_chan_t           r_i,
  input  wire                          r_valid_i,
  input  wire                          r_ready_i
);

  localparam int unsigned num_cnt = 1 << `DMX_LOOK_BITS;

  // one in-flight count and one port per low id
  logic [num_cnt-1:0][`DMX_CNT_W-1:0] cnt_q;
  demux_pkg::sel_t [num_cnt-1:0]      sel_q;

  logic [num_cnt-1:0]        push_en;
  logic [num_cnt-1:0]        pop_en;
  logic [num_cnt-1:0]        cnt_full;
  logic                      pop;
  logic [`DMX_LOOK_BITS-1:0] pop_id;

  // --------------------
  // lookup
  // --------------------
  assign lookup_sel_o = sel_q[lookup_id_i];
  assign occupied_o   = |cnt_q[lookup_id_i];
  // any full counter blocks every new request
  assign full_o       = |cnt_full;

  // a burst is done once its last beat leaves the slave port
  assign pop    = r_valid_i && r_ready_i && r_i.last;
  assign pop_id = r_i.id[`DMX_LOOK_BITS-1:0];

  // --------------------
  // per-id decode
  // --------------------
  always_comb begin
    for (int i = 0; i < num_cnt; i++) begin
      push_en[i]  = push_i && (push_id_i == i);
      pop_en[i]   = pop && (pop_id == i);
      cnt_full[i] = &cnt_q[i];
    end
  end

  // --------------------
  // counters and stored selects
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
      sel_q <= '0;
    end else begin
      for (int i = 0; i < num_cnt; i++) begin
        // push and pop together cancel out
        if (push_en[i] && !pop_en[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (pop_en[i] && !push_en[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
        // same id can only be pushed again to the same port while busy
        if (push_en[i]) begin
          sel_q[i] <= push_sel_i;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== ar_router.sv ====
`default_nettype none

`include "demux_settings.svh"

module ar_router (
  input  wire                                     clk_i,
  input  wire                                     rst_i,
  // request from the input register
  input  demux_pkg::ar_sel_t                      req_i,
  input  wire                                     req_valid_i,
  output logic                                    req_ready_o,
  // in-flight table
  input  demux_pkg::sel_t                         lookup_sel_i,
  input  wire                                     occupied_i,
  input  wire                                     full_i,
  output logic                                    push_o,
  // master AR ports
  output demux_pkg::ar_chan_t [`DMX_NUM_PORTS-1:0] mst_ar_o,
  output logic [`DMX_NUM_PORTS-1:0]               mst_ar_valid_o,
  input  wire [`DMX_NUM_PORTS-1:0]                mst_ar_ready_i
);

  demux_pkg::route_state_e state_q, state_d;

  // valid towards the selected port, before decode
  logic ar_valid;
  // ready of the selected port
  logic sel_ready;
  // ordering check: id free, or already heading to this same port
  logic order_ok;

  assign sel_ready = mst_ar_ready_i[req_i.sel];
  assign order_ok  = !occupied_i || (req_i.sel == lookup_sel_i);

  // --------------------
  // handshake FSM
  // --------------------
  always_comb begin
    state_d     = state_q;
    ar_valid    = 1'b0;
    req_ready_o = 1'b0;
    push_o      = 1'b0;
    case (state_q)
      demux_pkg::ROUTE_LOCKED: begin
        // decision already made, hold valid whatever the table says now
        ar_valid = 1'b1;
        if (sel_ready) begin
          req_ready_o = 1'b1;
          push_o      = 1'b1;
          state_d     = demux_pkg::ROUTE_IDLE;
        end
      end
      default: begin
        if (req_valid_i && !full_i && order_ok) begin
          ar_valid = 1'b1;
          if (sel_ready) begin
            // accepted at once, count it in flight
            req_ready_o = 1'b1;
            push_o      = 1'b1;
          end else begin
            state_d = demux_pkg::ROUTE_LOCKED;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= demux_pkg::ROUTE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------
  // master side fan-out
  // --------------------
  // payload goes to every port, only the selected one sees valid
  always_comb begin
    for (int i = 0; i < `DMX_NUM_PORTS; i++) begin
      mst_ar_o[i]       = req_i.ar;
      mst_ar_valid_o[i] = ar_valid && (req_i.sel == i);
    end
  end

endmodule

`default_nettype wire

// ==== r_resp_arbiter.sv ====
`default_nettype none

`include "demux_settings.svh"

module r_resp_arbiter (
  input  wire                                    clk_i,
  input  wire                                    rst_i,
  // master R ports
  input  demux_pkg::r_chan_t [`DMX_NUM_PORTS-1:0] mst_r_i,
  input  wire [`DMX_NUM_PORTS-1:0]               mst_r_valid_i,
  output logic [`DMX_NUM_PORTS-1:0]              mst_r_ready_o,
  // merged slave R port
  output demux_pkg::r_chan_t                     slv_r_o,
  output logic                                   slv_r_valid_o,
  input  wire                                    slv_r_ready_i
);

  // first port to look at when unlocked
  demux_pkg::sel_t ptr_q, ptr_d;
  // grant held through a burst
  logic            lock_q, lock_d;
  demux_pkg::sel_t lock_idx_q;

  demux_pkg::sel_t gnt_idx;
  demux_pkg::sel_t cand;
  logic            found;
  logic            last_xfer;

  // --------------------
  // grant selection
  // --------------------
  always_comb begin
    gnt_idx = lock_idx_q;
    cand    = lock_idx_q;
    found   = 1'b0;
    if (lock_q) begin
      found = mst_r_valid_i[lock_idx_q];
    end else begin
      // scan ports starting at the pointer, wrapping around
      for (int k = 0; k < `DMX_NUM_PORTS; k++) begin
        cand = demux_pkg::sel_t'((int'(ptr_q) + k) % `DMX_NUM_PORTS);
        if (!found && mst_r_valid_i[cand]) begin
          found   = 1'b1;
          gnt_idx = cand;
        end
      end
    end
  end

  // zero-latency path from the granted port
  assign slv_r_o       = mst_r_i[gnt_idx];
  assign slv_r_valid_o = found;

  // back-pressure reaches the granted port only
  always_comb begin
    for (int i = 0; i < `DMX_NUM_PORTS; i++) begin
      mst_r_ready_o[i] = found && slv_r_ready_i && (gnt_idx == i);
    end
  end

  // --------------------
  // lock and pointer update
  // --------------------
  assign last_xfer = found && slv_r_ready_i && slv_r_o.last;

  always_comb begin
    ptr_d  = ptr_q;
    // stay on this port through stalls and gaps until its last beat leaves
    lock_d = (lock_q || found) && !last_xfer;
    if (last_xfer) begin
      // next search starts after the port just served
      ptr_d = demux_pkg::sel_t'((int'(gnt_idx) + 1) % `DMX_NUM_PORTS);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      ptr_q      <= ptr_d;
      lock_q     <= lock_d;
      lock_idx_q <= gnt_idx;
    end
  end

endmodule

`default_nettype wire

// ==== read_demux_top.sv ====
`default_nettype none

`include "demux_settings.svh"

module read_demux_top (
  input  wire                                     clk_i,
  input  wire                                     rst_i,
  // slave AR
  input  demux_pkg::ar_chan_t                     slv_ar_i,
  input  demux_pkg::sel_t                         slv_ar_sel_i,
  input  wire                                     slv_ar_valid_i,
  output logic                                    slv_ar_ready_o,
  // slave R
  output demux_pkg::r_chan_t                      slv_r_o,
  output logic                                    slv_r_valid_o,
  input  wire                                     slv_r_ready_i,
  // master AR
  output demux_pkg::ar_chan_t [`DMX_NUM_PORTS-1:0] mst_ar_o,
  output logic [`DMX_NUM_PORTS-1:0]               mst_ar_valid_o,
  input  wire [`DMX_NUM_PORTS-1:0]                mst_ar_ready_i,
  // master R
  input  demux_pkg::r_chan_t [`DMX_NUM_PORTS-1:0]  mst_r_i,
  input  wire [`DMX_NUM_PORTS-1:0]                mst_r_valid_i,
  output logic [`DMX_NUM_PORTS-1:0]               mst_r_ready_o
);

  // request out of the spill register
  demux_pkg::ar_sel_t ar_req;
  logic               ar_req_valid;
  logic               ar_req_ready;

  // table lookup and push
  demux_pkg::sel_t lookup_sel;
  logic            occupied;
  logic            cnt_full;
  logic            push;

  // --------------------
  // AR path
  // --------------------
  ar_input_reg u_ar_input_reg (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_i        ({slv_ar_i, slv_ar_sel_i}),
    .in_valid_i  (slv_ar_valid_i),
    .in_ready_o  (slv_ar_ready_o),
    .out_o       (ar_req),
    .out_valid_o (ar_req_valid),
    .out_ready_i (ar_req_ready)
  );

  ar_router u_ar_router (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_i          (ar_req),
    .req_valid_i    (ar_req_valid),
    .req_ready_o    (ar_req_ready),
    .lookup_sel_i   (lookup_sel),
    .occupied_i     (occupied),
    .full_i         (cnt_full),
    .push_o         (push),
    .mst_ar_o       (mst_ar_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i)
  );

  // lookup and push both use the request at the router
  id_inflight_table u_id_inflight_table (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .lookup_id_i  (ar_req.ar.id[`DMX_LOOK_BITS-1:0]),
    .lookup_sel_o (lookup_sel),
    .occupied_o   (occupied),
    .full_o       (cnt_full),
    .push_i       (push),
    .push_id_i    (ar_req.ar.id[`DMX_LOOK_BITS-1:0]),
    .push_sel_i   (ar_req.sel),
    .r_i          (slv_r_o),
    .r_valid_i    (slv_r_valid_o),
    .r_ready_i    (slv_r_ready_i)
  );

  // --------------------
  // R path
  // --------------------
  r_resp_arbiter u_r_resp_arbiter (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .mst_r_i       (mst_r_i),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_ready_o (mst_r_ready_o),
    .slv_r_o       (slv_r_o),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_ready_i (slv_r_ready_i)
  );

endmodule

`default_nettype wire

// ==== demux_checker.sv ====
`default_nettype none

`include "demux_settings.svh"

module demux_checker (
  input  wire                                     clk_i,
  input  wire                                     rst_i,
  // slave port
  input  demux_pkg::ar_chan_t                     slv_ar_i,
  input  demux_pkg::sel_t                         slv_ar_sel_i,
  input  wire                                     slv_ar_valid_i,
  input  wire                                     slv_ar_ready_i,
  input  demux_pkg::r_chan_t                      slv_r_i,
  input  wire                                     slv_r_valid_i,
  input  wire                                     slv_r_ready_i,
  // master ports
  input  demux_pkg::ar_chan_t [`DMX_NUM_PORTS-1:0] mst_ar_i,
  input  wire [`DMX_NUM_PORTS-1:0]                mst_ar_valid_i,
  input  wire [`DMX_NUM_PORTS-1:0]                mst_ar_ready_i,
  input  wire [`DMX_NUM_PORTS-1:0]                mst_r_ready_i,
  // test sequencing
  input  wire [7:0]                               test_num_i,
  input  wire                                     test_done_i,
  output int                                      err_count_o,
  output int                                      pending_o
);

  localparam int max_open = (1 << `DMX_CNT_W) - 1;

  // taken on the slave port, not yet at a master port
  demux_pkg::ar_sel_t acc_q[$];
  // taken at a master port, no beat returned yet
  demux_pkg::ar_sel_t fly_q[$];
  // burst now crossing the slave R port
  demux_pkg::ar_sel_t cur;
  logic               in_burst;
  int                 beat_k;
  int                 test_errs;
  int                 rst_cycles;
  logic               rst_reported;

  // last edge samples, for the hold-until-ready rules
  logic [`DMX_NUM_PORTS-1:0]               prev_mvalid;
  logic [`DMX_NUM_PORTS-1:0]               prev_mready;
  demux_pkg::ar_chan_t [`DMX_NUM_PORTS-1:0] prev_mar;
  logic                                    prev_svalid;
  logic                                    prev_sready;
  demux_pkg::r_chan_t                      prev_sr;

  function automatic logic [`DMX_LOOK_BITS-1:0] low_id(input demux_pkg::id_t id);
    return id[`DMX_LOOK_BITS-1:0];
  endfunction

  task automatic report_err(input string msg);
    $display("ERR t=%0t: %s", $time, msg);
    err_count_o++;
    test_errs++;
  endtask

  // requests of this low id still waiting for their last beat
  function automatic int count_open(input logic [`DMX_LOOK_BITS-1:0] lid);
    int n;
    n = 0;
    foreach (fly_q[i]) begin
      if (low_id(fly_q[i].ar.id) == lid) begin
        n++;
      end
    end
    if (in_burst && low_id(cur.ar.id) == lid) begin
      n++;
    end
    return n;
  endfunction

  // open request of this low id bound for another port
  function automatic logic open_elsewhere(input logic [`DMX_LOOK_BITS-1:0] lid,
                                          input demux_pkg::sel_t psel);
    logic hit;
    hit = in_burst && low_id(cur.ar.id) == lid && cur.sel != psel;
    foreach (fly_q[i]) begin
      if (low_id(fly_q[i].ar.id) == lid && fly_q[i].sel != psel) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic check_reset();
    if (slv_ar_ready_i !== 1'b1) begin
      report_err($sformatf("slv_ar_ready_o is %b in reset, expected 1", slv_ar_ready_i));
    end
    if (mst_ar_valid_i !== '0) begin
      report_err($sformatf("mst_ar_valid_o is %b in reset, expected 0", mst_ar_valid_i));
    end
    if (slv_r_valid_i !== 1'b0) begin
      report_err($sformatf("slv_r_valid_o is %b in reset, expected 0", slv_r_valid_i));
    end
    if (mst_r_ready_i !== '0) begin
      report_err($sformatf("mst_r_ready_o is %b in reset, expected 0", mst_r_ready_i));
    end
  endtask

  // --------------------
  // master AR side
  // --------------------
  task automatic check_master_ar(input int p);
    demux_pkg::ar_sel_t exp;
    demux_pkg::sel_t    psel;
    psel = demux_pkg::sel_t'(p);
    if (prev_mvalid[p] && !prev_mready[p]) begin
      if (!mst_ar_valid_i[p]) begin
        report_err($sformatf("AR valid on port %0d dropped before ready", p));
      end else if (mst_ar_i[p] != prev_mar[p]) begin
        report_err($sformatf("AR payload on port %0d changed before ready", p));
      end
    end
    if (mst_ar_valid_i[p] && open_elsewhere(low_id(mst_ar_i[p].id), psel)) begin
      report_err($sformatf("AR id %0h on port %0d while open on another port",
                           mst_ar_i[p].id, p));
    end
    if (mst_ar_valid_i[p] && mst_ar_ready_i[p]) begin
      if (acc_q.size() == 0) begin
        report_err($sformatf("AR on port %0d with no request pending", p));
      end else begin
        exp = acc_q.pop_front();
        if (exp.sel != psel) begin
          report_err($sformatf("AR id %0h on port %0d, expected port %0d",
                               mst_ar_i[p].id, p, exp.sel));
        end else if (exp.ar != mst_ar_i[p]) begin
          report_err($sformatf("AR on port %0d is %h/%h/%h, expected %h/%h/%h", p,
                               mst_ar_i[p].id, mst_ar_i[p].addr, mst_ar_i[p].len,
                               exp.ar.id, exp.ar.addr, exp.ar.len));
        end
      end
      fly_q.push_back({mst_ar_i[p], psel});
      if (count_open(low_id(mst_ar_i[p].id)) > max_open) begin
        report_err($sformatf("more than %0d open requests for low id %0d", max_open,
                             low_id(mst_ar_i[p].id)));
      end
    end
  endtask

  // --------------------
  // slave R side
  // --------------------
  task automatic check_r_beat();
    int                        idx;
    demux_pkg::data_t          exp_data;
    logic                      exp_last;
    logic [`DMX_NUM_PORTS-1:0] exp_rdy;
    if (!in_burst) begin
      // oldest open request of this low id owns the burst
      idx = -1;
      foreach (fly_q[i]) begin
        if (idx < 0 && low_id(fly_q[i].ar.id) == low_id(slv_r_i.id)) begin
          idx = i;
        end
      end
      if (idx < 0) begin
        report_err($sformatf("R beat id %0h with no open request", slv_r_i.id));
        return;
      end
      cur = fly_q[idx];
      fly_q.delete(idx);
      in_burst = 1'b1;
      beat_k = 0;
    end
    // only the port that serves this burst sees ready
    exp_rdy          = '0;
    exp_rdy[cur.sel] = 1'b1;
    if (mst_r_ready_i != exp_rdy) begin
      report_err($sformatf("mst_r_ready_o is %b, expected port %0d only", mst_r_ready_i,
                           cur.sel));
    end
    exp_data = demux_pkg::data_t'(cur.ar.addr + beat_k);
    exp_last = (beat_k == cur.ar.len);
    if (slv_r_i.id != cur.ar.id) begin
      report_err($sformatf("R id %0h, expected %0h", slv_r_i.id, cur.ar.id));
    end
    if (slv_r_i.data != exp_data) begin
      report_err($sformatf("R data %h, expected %h", slv_r_i.data, exp_data));
    end
    if (slv_r_i.last != exp_last) begin
      report_err($sformatf("R last %b on beat %0d, expected %b", slv_r_i.last, beat_k,
                           exp_last));
    end
    if (slv_r_i.last || exp_last) begin
      in_burst = 1'b0;
      pending_o--;
    end else begin
      beat_k++;
    end
  endtask

  initial begin
    err_count_o  = 0;
    pending_o    = 0;
    test_errs    = 0;
    in_burst     = 1'b0;
    beat_k       = 0;
    rst_cycles   = 0;
    rst_reported = 1'b0;
    prev_mvalid  = '0;
    prev_mready  = '0;
    prev_svalid  = 1'b0;
    prev_sready  = 1'b0;
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      // flops hold reset values from the second reset edge on
      if (rst_cycles > 0) begin
        check_reset();
      end
      rst_cycles++;
    end else begin
      if (!rst_reported) begin
        $display("test 0 (reset state) done: %0d errors", test_errs);
        test_errs    = 0;
        rst_reported = 1'b1;
      end
      if (slv_ar_valid_i && slv_ar_ready_i) begin
        acc_q.push_back({slv_ar_i, slv_ar_sel_i});
        pending_o++;
      end
      if ($countones(mst_ar_valid_i) > 1) begin
        report_err($sformatf("mst_ar_valid_o %b is not one-hot", mst_ar_valid_i));
      end
      for (int p = 0; p < `DMX_NUM_PORTS; p++) begin
        check_master_ar(p);
      end
      // stalled beat must stay put
      if (prev_svalid && !prev_sready) begin
        if (!slv_r_valid_i || slv_r_i != prev_sr) begin
          report_err("slave R beat changed while stalled");
        end
      end
      // no master port sees ready unless a beat crosses the slave port
      if (!(slv_r_valid_i && slv_r_ready_i) && mst_r_ready_i != '0) begin
        report_err($sformatf("mst_r_ready_o is %b with no slave R transfer",
                             mst_r_ready_i));
      end
      if (slv_r_valid_i && slv_r_ready_i) begin
        check_r_beat();
      end
      if (test_done_i) begin
        $display("test %0d done: %0d errors", test_num_i, test_errs);
        test_errs = 0;
      end
    end
    prev_mvalid = mst_ar_valid_i;
    prev_mready = mst_ar_ready_i;
    prev_mar    = mst_ar_i;
    prev_svalid = slv_r_valid_i;
    prev_sready = slv_r_ready_i;
    prev_sr     = slv_r_i;
  end

endmodule

`default_nettype wire

// ==== demux_tb.sv ====
`default_nettype none

`include "demux_settings.svh"

module demux_tb;

  localparam int drive_dly  = 10;
  // responses are held back in this test so one counter fills up
  localparam int full_test  = 3;
  localparam int hold_len   = 30;
  localparam int wd_per_vec = 40;

  // one line of the vector file
  typedef struct packed {
    logic [7:0]          test;
    demux_pkg::ar_chan_t ar;
    demux_pkg::sel_t     sel;
    logic [7:0]          gap;
  } vec_t;

  logic                                     clk;
  logic                                     rst;
  demux_pkg::ar_chan_t                      slv_ar;
  demux_pkg::sel_t                          slv_ar_sel;
  logic                                     slv_ar_valid;
  logic                                     slv_ar_ready;
  demux_pkg::r_chan_t                       slv_r;
  logic                                     slv_r_valid;
  logic                                     slv_r_ready;
  demux_pkg::ar_chan_t [`DMX_NUM_PORTS-1:0] mst_ar;
  logic [`DMX_NUM_PORTS-1:0]                mst_ar_valid;
  wire [`DMX_NUM_PORTS-1:0]                 mst_ar_ready;
  wire demux_pkg::r_chan_t [`DMX_NUM_PORTS-1:0] mst_r;
  wire [`DMX_NUM_PORTS-1:0]                 mst_r_valid;
  logic [`DMX_NUM_PORTS-1:0]                mst_r_ready;

  logic [7:0] cur_test;
  logic       test_done;
  logic       hold_r;
  int         err_count;
  int         pending;
  int         wd_cycles;
  int         n_tests;
  vec_t       vec_q[$];

  read_demux_top UUT (
    .clk_i          (clk),
    .rst_i          (rst),
    .slv_ar_i       (slv_ar),
    .slv_ar_sel_i   (slv_ar_sel),
    .slv_ar_valid_i (slv_ar_valid),
    .slv_ar_ready_o (slv_ar_ready),
    .slv_r_o        (slv_r),
    .slv_r_valid_o  (slv_r_valid),
    .slv_r_ready_i  (slv_r_ready),
    .mst_ar_o       (mst_ar),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_ar_ready_i (mst_ar_ready),
    .mst_r_i        (mst_r),
    .mst_r_valid_i  (mst_r_valid),
    .mst_r_ready_o  (mst_r_ready)
  );

  demux_checker u_checker (
    .clk_i          (clk),
    .rst_i          (rst),
    .slv_ar_i       (slv_ar),
    .slv_ar_sel_i   (slv_ar_sel),
    .slv_ar_valid_i (slv_ar_valid),
    .slv_ar_ready_i (slv_ar_ready),
    .slv_r_i        (slv_r),
    .slv_r_valid_i  (slv_r_valid),
    .slv_r_ready_i  (slv_r_ready),
    .mst_ar_i       (mst_ar),
    .mst_ar_valid_i (mst_ar_valid),
    .mst_ar_ready_i (mst_ar_ready),
    .mst_r_ready_i  (mst_r_ready),
    .test_num_i     (cur_test),
    .test_done_i    (test_done),
    .err_count_o    (err_count),
    .pending_o      (pending)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // master port models
  // --------------------
  // each port queues the ARs it takes and answers them in order
  for (genvar p = 0; p < `DMX_NUM_PORTS; p++) begin : g_slave
    demux_pkg::ar_chan_t ar_q[$];
    demux_pkg::r_chan_t  r_beat;
    logic                ar_rdy;
    logic                r_vld;
    logic                ar_hs;
    logic                r_hs;
    int                  beat;
    int                  gap;

    assign mst_ar_ready[p] = ar_rdy;
    assign mst_r_valid[p]  = r_vld;
    assign mst_r[p]        = r_beat;

    initial begin
      ar_rdy = 1'b0;
      r_vld  = 1'b0;
      r_beat = '0;
      beat   = 0;
      gap    = 0;
      forever begin
        @(posedge clk);
        ar_hs = mst_ar_valid[p] && ar_rdy;
        r_hs  = r_vld && mst_r_ready[p];
        if (rst) begin
          ar_q.delete();
          beat = 0;
        end else begin
          if (ar_hs) begin
            ar_q.push_back(mst_ar[p]);
          end
          if (r_hs) begin
            if (r_beat.last) begin
              ar_q.delete(0);
              beat = 0;
            end else begin
              beat++;
            end
            gap = $urandom_range(0, 2);
          end
        end
        #drive_dly;
        if (rst) begin
          ar_rdy = 1'b0;
          r_vld  = 1'b0;
        end else begin
          ar_rdy = ($urandom_range(0, 3) != 0);
          // a beat on offer stays until taken
          if (r_hs || !r_vld) begin
            if (gap > 0) begin
              gap--;
              r_vld = 1'b0;
            end else if (ar_q.size() > 0 && !hold_r) begin
              r_beat.id   = ar_q[0].id;
              r_beat.data = demux_pkg::data_t'(ar_q[0].addr + beat);
              r_beat.last = (beat == ar_q[0].len);
              r_vld       = 1'b1;
            end else begin
              r_vld = 1'b0;
            end
          end
        end
      end
    end
  end

  // random back-pressure on the slave R port
  initial begin
    slv_r_ready = 1'b0;
    forever begin
      @(posedge clk);
      #drive_dly;
      slv_r_ready = !rst && ($urandom_range(0, 3) != 0);
    end
  end

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("timeout: not all responses returned");
    $display("Finished with errors");
    $finish;
  end

  // --------------------
  // stimulus
  // --------------------
  task automatic load_vectors(input int fd);
    string            line;
    int               rc;
    logic [7:0]       t;
    demux_pkg::id_t   id;
    demux_pkg::addr_t addr;
    demux_pkg::len_t  len;
    demux_pkg::sel_t  sel;
    logic [7:0]       gap;
    vec_t             v;
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      // # starts a comment line
      if (rc > 0 && line[0] != "#") begin
        if ($sscanf(line, "%d %h %h %h %d %d", t, id, addr, len, sel, gap) == 6) begin
          v.test    = t;
          v.ar.id   = id;
          v.ar.addr = addr;
          v.ar.len  = len;
          v.sel     = sel;
          v.gap     = gap;
          vec_q.push_back(v);
        end
      end
    end
  endtask

  // offer one request and hold it until the slave port takes it
  task automatic issue_req(input vec_t v);
    slv_ar       = v.ar;
    slv_ar_sel   = v.sel;
    slv_ar_valid = 1'b1;
    do @(posedge clk); while (!slv_ar_ready);
    #drive_dly;
    slv_ar_valid = 1'b0;
    repeat (v.gap) begin
      @(posedge clk);
      #drive_dly;
    end
  endtask

  // drain all bursts, then mark the end of the test
  task automatic close_test();
    if (hold_r) begin
      repeat (hold_len) begin
        @(posedge clk);
        #drive_dly;
      end
      hold_r = 1'b0;
    end
    while (pending != 0) begin
      @(posedge clk);
      #drive_dly;
    end
    test_done = 1'b1;
    @(posedge clk);
    #drive_dly;
    test_done = 1'b0;
  endtask

  task automatic run_vectors();
    foreach (vec_q[i]) begin
      if (vec_q[i].test != cur_test) begin
        if (cur_test != 0) begin
          close_test();
        end
        cur_test = vec_q[i].test;
        hold_r   = (cur_test == full_test);
        n_tests++;
      end
      issue_req(vec_q[i]);
    end
    if (cur_test != 0) begin
      close_test();
    end
  endtask

  initial begin
    int fd;
    int seed_rc;
    seed_rc      = $urandom(32'h80a8);
    rst          = 1'b1;
    slv_ar       = '0;
    slv_ar_sel   = '0;
    slv_ar_valid = 1'b0;
    cur_test     = '0;
    test_done    = 1'b0;
    hold_r       = 1'b0;
    wd_cycles    = 0;
    n_tests      = 0;
    fd = $fopen("demux_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file demux_vectors.txt");
      $display("Finished with errors");
      $finish;
    end else begin
      load_vectors(fd);
      $fclose(fd);
      wd_cycles = vec_q.size() * wd_per_vec;
      repeat (3) @(posedge clk);
      #drive_dly;
      rst = 1'b0;
      run_vectors();
      $display("tests %0d, requests %0d, errors %0d", n_tests, vec_q.size(), err_count);
      if (err_count == 0) begin
        $display("Finished with no errors");
      end else begin
        $display("Finished with errors");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
demux_pkg.sv
ar_input_reg.sv
id_inflight_table.sv
ar_router.sv
r_resp_arbiter.sv
read_demux_top.sv
demux_checker.sv
demux_tb.sv

// ==== demux_vectors.txt ====
# test id addr len sel gap, one read request per line
# test, sel and gap in decimal; id, addr and len in hex
1 0 1000 3 0 0
1 1 2000 0 1 1
1 2 3000 7 2 0
1 3 4000 2 3 0
1 4 1100 1 1 2
1 5 2100 5 2 0
1 6 3100 0 3 0
1 7 4100 4 0 1
2 9 5000 3 1 0
2 9 5100 1 2 0
2 9 5200 2 1 0
2 d 5300 0 3 0
2 5 5400 2 0 0
2 a 6000 5 2 0
2 a 6100 5 2 0
2 e 6200 1 0 0
3 c 7000 1 2 0
3 c 7100 1 2 0
3 c 7200 1 2 0
3 c 7300 1 2 0
3 c 7400 1 2 0
3 c 7500 1 2 0
3 c 7600 1 2 0
3 c 7700 1 2 0
4 3 8000 f 3 0
4 6 8100 7 0 0
4 1 8200 a 1 0
4 b 8300 2 2 0
4 f 8400 4 3 1
4 0 8500 6 0 0
